//--- hdl/alu_execute.sv
// Execute stage
// Operand register behind decode and the arithmetic and logic unit.
// The result is combinational over the registered operands and is
// captured by the result stage on the next edge

`default_nettype none

module alu_execute import core_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                issue,
    input  wire opcode_e       op,
    input  wire [reg_aw-1:0]   rd,
    input  wire [data_w-1:0]   opnd_a,     // Source A or old rd
    input  wire [data_w-1:0]   opnd_b,     // Source B or extended immediate
    output logic               ex_valid,
    output opcode_e            ex_op,
    output logic [reg_aw-1:0]  ex_rd,
    output logic [data_w-1:0]  ex_value,
    output logic               ex_writes   // Not nop, not hlt
);

    logic [data_w-1:0] a_q;
    logic [data_w-1:0] b_q;

    ////////////////////
    // Stage register
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= issue;                // Bubble when decode holds
    end

    // Payload only moves with an issue
    always_ff @(posedge clk) begin
        if (issue) begin
            ex_op <= op;
            ex_rd <= rd;
            a_q   <= opnd_a;
            b_q   <= opnd_b;
        end
    end

    ////////////////////
    // ALU
    ////////////////////
    always_comb begin
        case (ex_op)
            op_add,
            op_addi: ex_value = a_q + b_q;    // Wraps mod 2^16
            op_sub:  ex_value = a_q - b_q;
            op_and:  ex_value = a_q & b_q;
            op_or:   ex_value = a_q | b_q;
            op_xor:  ex_value = a_q ^ b_q;
            op_lli:  ex_value = b_q;          // Immediate passes through
            default: ex_value = '0;           // nop, hlt
        endcase
    end

    assign ex_writes = op_writes(ex_op);      // Interlock qualifies with ex_valid

endmodule

`default_nettype wire

//--- hdl/core_pkg.sv
// Core package
// Widths, operation codes and the instruction word layout shared by
// the three-stage core, its trace unit and the testbench

`default_nettype none

package core_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int data_w  = 16;  // Register and result width
    localparam int reg_aw  = 4;   // Sixteen registers, r0 reads zero
    localparam int pc_w    = 8;   // Program counter
    localparam int seq_w   = 16;  // Trace sequence numbers
    localparam int stamp_w = 32;  // Cycle stamp and held-cycle counter
    localparam int imm_w   = 8;   // Immediate field of the i view

    ////////////////////
    // Operations
    ////////////////////
    // Unlisted codes behave as nop everywhere
    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,  // rd = rs + rt
        op_sub  = 4'h2,  // rd = rs - rt
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_xor  = 4'h5,
        op_lli  = 4'h6,  // rd = sext(imm)
        op_addi = 4'h7,  // rd = rd + sext(imm)
        op_hlt  = 4'hf   // Stops fetch, sets halted in the result stage
    } opcode_e;

    // Instruction word, opcode on top in both views
    typedef union packed {
        struct packed {
            opcode_e           opcode;
            logic [reg_aw-1:0] rd;
            logic [reg_aw-1:0] rs;
            logic [reg_aw-1:0] rt;
        } r;  // Register form
        struct packed {
            opcode_e           opcode;
            logic [reg_aw-1:0] rd;
            logic [imm_w-1:0]  imm;
        } i;  // Immediate form
    } instr_u;

    // Operations that write rd and retire
    function automatic logic op_writes(input opcode_e op);
        case (op)
            op_add, op_sub, op_and, op_or, op_xor: return 1'b1;
            op_lli, op_addi:                       return 1'b1;
            default:                               return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hdl/core_top.sv
// Core top level
// Three-stage pipeline (fetch/decode, execute, result) with the
// trace unit alongside. Instruction memory sits outside

`default_nettype none

module core_top import core_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                stall,
    input  wire instr_u        instr,          // From instruction ROM at pc
    output logic [pc_w-1:0]    pc,
    output logic               retire,
    output logic [reg_aw-1:0]  retire_rd,
    output logic [data_w-1:0]  retire_value,
    output logic [seq_w-1:0]   retire_seq,
    output logic [stamp_w-1:0] retire_stamp,
    output logic [stamp_w-1:0] held_count,
    output logic               halted
);

    ////////////////////
    // Interconnect
    ////////////////////
    logic              issue;      // Decode to execute and trace
    logic              hold;
    opcode_e           op;
    logic [reg_aw-1:0] rd;
    logic [data_w-1:0] opnd_a;
    logic [data_w-1:0] opnd_b;
    logic              ex_valid;   // Execute to result and interlock
    opcode_e           ex_op;
    logic [reg_aw-1:0] ex_rd;
    logic [data_w-1:0] ex_value;
    logic              ex_writes;
    logic              wr_en;      // Register file write port
    logic [reg_aw-1:0] wr_rd;
    logic [data_w-1:0] wr_value;
    logic [reg_aw-1:0] rd_a_idx;   // Register file read ports
    logic [reg_aw-1:0] rd_b_idx;
    logic [data_w-1:0] rd_a_data;
    logic [data_w-1:0] rd_b_data;

    // Port names match the wires above one to one
    fetch_decode     fetch_decode_i     (.*);
    alu_execute      alu_execute_i      (.*);
    result_writeback result_writeback_i (.*);
    pipe_trace       pipe_trace_i       (.*);

endmodule

`default_nettype wire

//--- hdl/fetch_decode.sv
// Fetch and decode stage
// Program counter, instruction decode through the union views,
// register reads with same-cycle write merge, RAW interlock
// against execute, and the stall and halt hold

`default_nettype none

module fetch_decode import core_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                stall,      // External freeze of this stage
    input  wire instr_u        instr,      // Word at pc, read combinationally
    input  wire                ex_valid,   // Execute slot occupancy
    input  wire [reg_aw-1:0]   ex_rd,
    input  wire                ex_writes,
    input  wire                wr_en,      // Register file write port
    input  wire [reg_aw-1:0]   wr_rd,
    input  wire [data_w-1:0]   wr_value,
    output logic [reg_aw-1:0]  rd_a_idx,   // Register file read ports
    output logic [reg_aw-1:0]  rd_b_idx,
    input  wire [data_w-1:0]   rd_a_data,
    input  wire [data_w-1:0]   rd_b_data,
    output logic [pc_w-1:0]    pc,
    output logic               issue,      // Decode moves into execute
    output logic               hold,       // Decode has a word but keeps it
    output opcode_e            op,
    output logic [reg_aw-1:0]  rd,
    output logic [data_w-1:0]  opnd_a,
    output logic [data_w-1:0]  opnd_b
);

    logic              halt_issued;  // hlt has left decode, no more fetch
    logic              is_imm;
    logic              use_a;        // Source A is a real dependency
    logic              use_b;
    logic              hazard;       // RAW against execute, one bubble
    logic [data_w-1:0] a_merged;
    logic [data_w-1:0] b_merged;
    logic [data_w-1:0] imm_ext;

    ////////////////////
    // Decode
    ////////////////////
    always_comb begin
        op     = instr.r.opcode;                   // Same bits in both views
        rd     = instr.r.rd;
        is_imm = (op == op_lli) || (op == op_addi);
        use_a  = 1'b0;
        use_b  = 1'b0;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor: begin
                use_a = 1'b1;
                use_b = 1'b1;
            end
            op_addi: use_a = 1'b1;                 // Old rd value
            default: ;                             // lli, nop, hlt read nothing
        endcase
        rd_a_idx = (op == op_addi) ? instr.i.rd : instr.r.rs;
        rd_b_idx = instr.r.rt;
        imm_ext  = {{(data_w-imm_w){instr.i.imm[imm_w-1]}}, instr.i.imm};
    end

    // Write in the result stage lands this cycle, take it directly
    always_comb begin
        a_merged = rd_a_data;
        b_merged = rd_b_data;
        if (wr_en && (wr_rd == rd_a_idx) && (rd_a_idx != '0))
            a_merged = wr_value;
        if (wr_en && (wr_rd == rd_b_idx) && (rd_b_idx != '0))
            b_merged = wr_value;
        opnd_a = a_merged;
        opnd_b = is_imm ? imm_ext : b_merged;
    end

    ////////////////////
    // Interlock and hold
    ////////////////////
    always_comb begin
        hazard = ex_valid && ex_writes && (ex_rd != '0) &&
                 ((use_a && (rd_a_idx == ex_rd)) || (use_b && (rd_b_idx == ex_rd)));
        issue  = !halt_issued && !stall && !hazard;
        hold   = !halt_issued && !issue;      // Nothing left to hold after hlt
    end

    // Program counter and halt flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= '0;
            halt_issued <= 1'b0;
        end else if (issue) begin
            pc <= pc + 1'b1;
            if (op == op_hlt)
                halt_issued <= 1'b1;          // Sticky until reset
        end
    end

endmodule

`default_nettype wire

//--- hdl/pipe_trace.sv
// Pipeline trace unit
// Gives each issued instruction a sequence number and carries it
// through the execute and result slots beside the data path.
// Also runs the cycle stamp and the held-cycle counter

`default_nettype none

module pipe_trace import core_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                issue,
    input  wire                hold,
    input  wire                halted,
    output logic [seq_w-1:0]   retire_seq,    // Identity in the result slot
    output logic [stamp_w-1:0] retire_stamp,  // Cycles since reset release
    output logic [stamp_w-1:0] held_count
);

    logic [seq_w-1:0] next_seq;  // Identity of the word in decode
    logic [seq_w-1:0] ex_seq;    // Identity in the execute slot

    ////////////////////
    // Stage identities
    ////////////////////
    // Decode identity only moves on issue, so it survives stall and halt.
    // The execute slot keeps its last identity through bubbles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_seq <= '0;
            ex_seq   <= '0;
        end else if (issue) begin
            next_seq <= next_seq + 1'b1;      // nop takes a number too
            ex_seq   <= next_seq;
        end
    end

    // Result slot follows execute every cycle like the data path
    always_ff @(posedge clk) begin
        if (!rst_n)
            retire_seq <= '0;
        else
            retire_seq <= ex_seq;             // Meaningful only with retire
    end

    ////////////////////
    // Counters
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n)
            retire_stamp <= '0;
        else
            retire_stamp <= retire_stamp + 1'b1;  // Free running
    end

    // Held cycles, stops counting once the core has halted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_count <= '0;
        end else if (hold && !halted) begin
            held_count <= held_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/result_writeback.sv
// Result stage
// Captures the execute result, writes it into the sixteen-entry
// register file and raises retire for writing operations.
// Sets the sticky halted flag when hlt arrives here

`default_nettype none

module result_writeback import core_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                ex_valid,
    input  wire opcode_e       ex_op,
    input  wire [reg_aw-1:0]   ex_rd,
    input  wire [data_w-1:0]   ex_value,
    input  wire [reg_aw-1:0]   rd_a_idx,   // Read ports for decode
    input  wire [reg_aw-1:0]   rd_b_idx,
    output logic [data_w-1:0]  rd_a_data,
    output logic [data_w-1:0]  rd_b_data,
    output logic               wr_en,      // Write port, also seen by decode
    output logic [reg_aw-1:0]  wr_rd,
    output logic [data_w-1:0]  wr_value,
    output logic               retire,
    output logic [reg_aw-1:0]  retire_rd,
    output logic [data_w-1:0]  retire_value,
    output logic               halted
);

    logic              res_valid;
    opcode_e           res_op;
    logic [reg_aw-1:0] res_rd;
    logic [data_w-1:0] res_value;
    logic [data_w-1:0] regs [2**reg_aw];      // Entry 0 never written

    ////////////////////
    // Stage register
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            res_valid <= ex_valid;
            if (ex_valid && (ex_op == op_hlt))
                halted <= 1'b1;               // High while hlt sits here, then sticky
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            res_op    <= ex_op;
            res_rd    <= ex_rd;
            res_value <= ex_value;
        end
    end

    // Write port
    assign wr_en    = res_valid && op_writes(res_op);
    assign wr_rd    = res_rd;
    assign wr_value = res_value;

    ////////////////////
    // Register file
    ////////////////////
    always_ff @(posedge clk) begin
        if (wr_en && (wr_rd != '0))
            regs[wr_rd] <= wr_value;
    end

    // Stored values, decode merges the write landing this cycle
    assign rd_a_data = (rd_a_idx == '0) ? '0 : regs[rd_a_idx];
    assign rd_b_data = (rd_b_idx == '0) ? '0 : regs[rd_b_idx];

    // Retirement report
    assign retire       = wr_en;              // nop and hlt never retire
    assign retire_rd    = res_rd;
    assign retire_value = res_value;

endmodule

`default_nettype wire

//--- sim.f
hdl/core_pkg.sv
hdl/fetch_decode.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/pipe_trace.sv
hdl/core_top.sv
test/core_chk.sv
test/core_tb.sv

//--- test/core_chk.sv
// Protocol checks on the core top level
// Quiet reset, sticky halt, no retire once halted and rising
// sequence numbers on retire

`default_nettype none

module core_chk import core_pkg::*; (
    input wire             clk,
    input wire             rst_n,
    input wire             retire,
    input wire             halted,
    input wire [seq_w-1:0] retire_seq
);

    timeunit 1ns;
    timeprecision 100ps;

    int               fail_count = 0;  // Failed assertions so far
    logic             seen;            // A retire since reset
    logic [seq_w-1:0] last_seq;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen <= 1'b0;
        end else if (retire) begin
            seen     <= 1'b1;
            last_seq <= retire_seq;
        end
    end

    ////////////////////
    // Assertions
    ////////////////////
    // Sync reset clears both one edge after it is seen
    reset_quiet: assert property (@(posedge clk) !rst_n |=> !retire && !halted)
        else begin
            $error("retire or halted high under reset");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else begin
            $error("halted dropped without reset");
            fail_count++;
        end

    no_retire_halted: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !retire)
        else begin
            $error("retire while halted");
            fail_count++;
        end

    seq_rising: assert property (@(posedge clk) disable iff (!rst_n)
                                 retire && seen |-> retire_seq > last_seq)
        else begin
            $error("retire_seq did not increase");
            fail_count++;
        end

endmodule

bind core_top core_chk chk_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .retire     (retire),
    .halted     (halted),
    .retire_seq (retire_seq)
);

`default_nettype wire

//--- test/core_tb.sv
// Core testbench
// Directed tests against a ROM model of instruction memory and an
// in-order reference model of the register results

`default_nettype none

module core_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cycles = 4 * 32 * 4 + 200;  // Tests x words x cycles, plus margin

    logic               clk;
    logic               rst_n;
    logic               stall;
    instr_u             instr;
    logic [pc_w-1:0]    pc;
    logic               retire;
    logic [reg_aw-1:0]  retire_rd;
    logic [data_w-1:0]  retire_value;
    logic [seq_w-1:0]   retire_seq;
    logic [stamp_w-1:0] retire_stamp;
    logic [stamp_w-1:0] held_count;
    logic               halted;

    instr_u      rom [2**pc_w];  // Instruction memory
    instr_u      prog [$];       // Program under test, from address 0
    logic [35:0] exp_q [$];      // Expected retires {seq, rd, value}
    int          hlt_index;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;

    assign instr = rom[pc];      // Combinational fetch

    core_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Global run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > max_cycles) begin
            $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED %0t %s: got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    // Fills the ROM and runs the program in order up to hlt
    task automatic load_program();
        logic [data_w-1:0] regs [2**reg_aw];
        logic [data_w-1:0] imm_ext;
        logic [data_w-1:0] value;
        logic              writes;
        instr_u            w;
        int                a;
        for (a = 0; a < 2**pc_w; a++)
            rom[a] = {op_nop, 4'h0, a[7:0]};    // Spare nops tagged with their address
        foreach (prog[i])
            rom[i] = prog[i];
        foreach (regs[r])
            regs[r] = '0;
        exp_q.delete();
        hlt_index = -1;
        for (a = 0; (a < prog.size()) && (hlt_index < 0); a++) begin
            w       = prog[a];
            imm_ext = w.i.imm;
            if (w.i.imm >= 8'h80)
                imm_ext = imm_ext - 16'h0100;    // Negative immediate, two's complement
            value   = '0;
            writes  = 1'b1;
            case (w.r.opcode)
                op_add:  value = regs[w.r.rs] + regs[w.r.rt];
                op_sub:  value = regs[w.r.rs] - regs[w.r.rt];
                op_and:  value = regs[w.r.rs] & regs[w.r.rt];
                op_or:   value = regs[w.r.rs] | regs[w.r.rt];
                op_xor:  value = regs[w.r.rs] ^ regs[w.r.rt];
                op_lli:  value = imm_ext;
                op_addi: value = regs[w.i.rd] + imm_ext;
                default: writes = 1'b0;          // nop, hlt, spare codes
            endcase
            if (w.r.opcode == op_hlt)
                hlt_index = a;
            if (writes) begin
                exp_q.push_back({a[15:0], w.r.rd, value});  // Sequence number is the index
                if (w.r.rd != '0)
                    regs[w.r.rd] = value;
            end
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        stall = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // State left by the last reset edge
        check_value("pc", pc, 0);
        check_value("retire", retire, 0);
        check_value("halted", halted, 0);
        check_value("held_count", held_count, 0);
        check_value("retire_stamp", retire_stamp, 0);
    endtask

    // Runs until halted, then watches the frozen core for extra cycles
    task automatic run_program(input logic rand_stall, input int extra);
        int              c;
        int              last_move;
        int              halt_at;
        logic [pc_w-1:0] prev_pc;
        logic [31:0]     rnd;
        logic [35:0]     entry;
        c         = 0;
        last_move = -1;
        halt_at   = -1;
        prev_pc   = pc;
        while ((halt_at < 0) || (c <= halt_at + extra)) begin
            rnd   = $urandom;
            stall = rand_stall & rnd[0];         // Roughly half the cycles
            @(negedge clk);
            if (pc !== prev_pc)
                last_move = c;                   // Issue in cycle c-1
            if (halt_at >= 0) begin
                check_value("pc", pc, prev_pc);  // Fetch stopped
                check_value("halted", halted, 1);
            end else if (halted) begin
                halt_at = c;
                // hlt issued in the cycle before pc last moved
                check_value("halted delay", c - (last_move - 1), 2);
            end
            if (retire) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Retire at %0t with no instruction left to retire", $time);
                end else begin
                    entry = exp_q.pop_front();
                    check_value("retire_seq", retire_seq, entry[35:20]);
                    check_value("retire_rd", retire_rd, entry[19:16]);
                    check_value("retire_value", retire_value, entry[15:0]);
                    check_value("retire_stamp", retire_stamp, c);  // Cycles since release
                end
            end
            prev_pc = pc;
            c++;
            @(posedge clk);
            #1;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d instructions were never retired", exp_q.size());
        end
        check_value("final pc", pc, hlt_index + 1);
    endtask

    ////////////////////
    // Tests
    ////////////////////
    // No word depends on the one just before it
    task automatic load_mixed();
        prog = '{
            {op_lli,  4'd1, 8'h05},
            {op_lli,  4'd2, 8'hfd},              // -3
            {op_lli,  4'd3, 8'h7f},
            {op_add,  4'd4, 4'd1, 4'd2},         // r2 through write-through
            {op_sub,  4'd5, 4'd1, 4'd3},         // Wraps
            {op_and,  4'd6, 4'd2, 4'd3},
            {op_or,   4'd7, 4'd4, 4'd5},
            {op_xor,  4'd8, 4'd2, 4'd1},
            {op_addi, 4'd3, 8'h80},              // r3 goes to all ones
            {op_nop,  12'h000},
            {op_addi, 4'd1, 8'h10},
            {op_sub,  4'd10, 4'd3, 4'd7},
            {op_or,   4'd12, 4'd5, 4'd0},        // r0 reads zero
            {op_hlt,  12'h000},
            {op_lli,  4'd13, 8'h11}              // Past hlt
        };
        load_program();
    endtask

    task automatic test_reset_state();
        load_mixed();
        apply_reset();
        repeat (6) @(posedge clk);
        #1;
        apply_reset();                           // Mid-program reset back to idle
    endtask

    task automatic test_independent();
        load_mixed();
        apply_reset();
        run_program(1'b0, 2);
        check_value("held_count", held_count, 0);
    endtask

    task automatic test_dependent();
        prog = '{
            {op_lli,  4'd1, 8'h03},
            {op_addi, 4'd1, 8'h04},              // On r1
            {op_lli,  4'd2, 8'h10},
            {op_add,  4'd3, 4'd2, 4'd1},         // On r2
            {op_xor,  4'd4, 4'd3, 4'd1},         // On r3
            {op_lli,  4'd5, 8'hf0},
            {op_sub,  4'd6, 4'd5, 4'd4},         // On r5
            {op_hlt,  12'h000}
        };
        load_program();
        apply_reset();
        run_program(1'b0, 2);
        check_value("held_count", held_count, 4);  // One bubble per dependent pair
    endtask

    task automatic test_random_stall();
        load_mixed();
        apply_reset();
        run_program(1'b1, 2);
    endtask

    task automatic test_halt();
        prog = '{
            {op_lli,  4'd1, 8'h01},
            {op_nop,  12'h000},                  // Sequence 1, never retires
            {op_addi, 4'd1, 8'h7f},
            {op_lli,  4'd2, 8'h80},
            {op_hlt,  12'h000},
            {op_lli,  4'd3, 8'h33},              // Never issues
            {op_add,  4'd4, 4'd1, 4'd2}
        };
        load_program();
        apply_reset();
        run_program(1'b0, 20);
    endtask

    initial begin
        void'($urandom(32'h410b));               // Fixed seed for the stall pattern
        rst_n    = 1'b0;
        stall    = 1'b0;
        prog.delete();
        load_program();                          // ROM filled from time 0
        test_reset_state();
        test_independent();
        test_dependent();
        test_random_stall();
        test_halt();
        $display("Checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, dut_i.chk_i.fail_count);
        if ((errors == 0) && (dut_i.chk_i.fail_count == 0))
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
